/* l1l2_bridge_top.f */
rtl/l1l2_pkg.sv
rtl/l1_miss_arbiter.sv
rtl/l2_req_latch.sv
rtl/l2_line_store.sv
rtl/l1l2_bridge_top.sv
tests/tb_l1l2_bridge.sv

/* rtl/l1_miss_arbiter.sv */
// miss arbiter between instruction and data cache
// grants one miss at a time, data cache first, and routes the completion
// back to the cache that owns the transaction

`timescale 1ns/1ps
`default_nettype none

module l1_miss_arbiter
    import l1l2_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,

    input  logic [ADDR_W-1:0] icache_addr,
    input  logic              icache_req,
    output logic              icache_data_ok,
    output logic [LINE_W-1:0] icache_line,

    input  logic [ADDR_W-1:0] dcache_addr,
    input  logic [WORD_W-1:0] dcache_wdata,
    input  logic              dcache_req,
    input  logic              dcache_wr,
    input  logic [3:0]        dcache_wstrb,
    output logic              dcache_data_ok,
    output logic [LINE_W-1:0] dcache_line,

    output logic [ADDR_W-1:0] l2_addr,
    output logic [WORD_W-1:0] l2_wdata,
    output logic              l2_req,
    output logic              l2_wr,
    output logic [3:0]        l2_wstrb,
    input  logic              l2_data_ok,
    input  logic [LINE_W-1:0] l2_line
);

    logic [2:0] state;
    logic [2:0] next_state;
    logic       grant;
    logic       busy;
    logic       done;

    always_comb begin
        next_state = state;
        case (state)
            ARB_IDLE: begin
                // dcache write or read beats an icache read
                if (dcache_req) begin
                    next_state = dcache_wr ? ARB_D_W : ARB_D_R;
                end else if (icache_req) begin
                    next_state = ARB_I_R;
                end
            end
            ARB_I_R, ARB_D_R, ARB_D_W: begin
                if (l2_data_ok) begin
                    next_state = ARB_RELEASE;
                end
            end
            ARB_RELEASE: next_state = ARB_IDLE;
            default:     next_state = ARB_IDLE;
        endcase
    end

    assign grant = (state == ARB_IDLE) && (next_state != ARB_IDLE);
    assign busy  = (state == ARB_I_R) || (state == ARB_D_R) || (state == ARB_D_W);
    assign done  = busy && l2_data_ok;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state          <= ARB_IDLE;
            l2_req         <= 1'b0;
            icache_data_ok <= 1'b0;
            dcache_data_ok <= 1'b0;
        end else begin
            state          <= next_state;
            icache_data_ok <= done && (state == ARB_I_R);
            dcache_data_ok <= done && (state != ARB_I_R);
            if (grant) begin
                l2_req <= 1'b1;
            end else if (done) begin
                l2_req <= 1'b0;
            end
        end
    end

    // request payload, held on the L2 side until completion
    always_ff @(posedge clk) begin
        if (grant) begin
            if (next_state == ARB_I_R) begin
                l2_addr  <= icache_addr;
                l2_wdata <= '0;
                l2_wr    <= 1'b0;
                l2_wstrb <= 4'b0000;
            end else begin
                l2_addr  <= dcache_addr;
                l2_wdata <= dcache_wdata;
                l2_wr    <= dcache_wr;
                l2_wstrb <= dcache_wstrb;
            end
        end
    end

    // returned line goes to the owner only, writes bring back nothing
    always_ff @(posedge clk) begin
        if (l2_data_ok && (state == ARB_I_R)) begin
            icache_line <= l2_line;
        end
        if (l2_data_ok && (state == ARB_D_R)) begin
            dcache_line <= l2_line;
        end
    end

endmodule

`default_nettype wire

/* rtl/l1l2_bridge_top.sv */
// L1/L2 bridge top level
// miss arbiter, request latch and line store in a three-stage chain

`timescale 1ns/1ps
`default_nettype none

module l1l2_bridge_top
    import l1l2_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,

    input  logic [ADDR_W-1:0] icache_addr,
    input  logic              icache_req,
    output logic              icache_data_ok,
    output logic [LINE_W-1:0] icache_line,

    input  logic [ADDR_W-1:0] dcache_addr,
    input  logic [WORD_W-1:0] dcache_wdata,
    input  logic              dcache_req,
    input  logic              dcache_wr,
    input  logic [3:0]        dcache_wstrb,
    output logic              dcache_data_ok,
    output logic [LINE_W-1:0] dcache_line
);

    // arbiter to latch
    logic [ADDR_W-1:0] l2_addr;
    logic [WORD_W-1:0] l2_wdata;
    logic              l2_req;
    logic              l2_wr;
    logic [3:0]        l2_wstrb;
    logic              l2_data_ok;
    logic [LINE_W-1:0] l2_line;

    // latch to store
    logic                  cmd_valid;
    logic                  cmd_wr;
    logic [INDEX_W-1:0]    cmd_index;
    logic [WORD_SEL_W-1:0] cmd_word;
    logic [3:0]            cmd_wstrb;
    logic [WORD_W-1:0]     cmd_wdata;
    logic                  rsp_valid;
    logic [LINE_W-1:0]     rsp_line;

    l1_miss_arbiter u_arbiter (
        .clk            (clk),
        .rstn           (rstn),
        .icache_addr    (icache_addr),
        .icache_req     (icache_req),
        .icache_data_ok (icache_data_ok),
        .icache_line    (icache_line),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_wstrb   (dcache_wstrb),
        .dcache_data_ok (dcache_data_ok),
        .dcache_line    (dcache_line),
        .l2_addr        (l2_addr),
        .l2_wdata       (l2_wdata),
        .l2_req         (l2_req),
        .l2_wr          (l2_wr),
        .l2_wstrb       (l2_wstrb),
        .l2_data_ok     (l2_data_ok),
        .l2_line        (l2_line)
    );

    l2_req_latch u_latch (
        .clk        (clk),
        .rstn       (rstn),
        .l2_addr    (l2_addr),
        .l2_wdata   (l2_wdata),
        .l2_req     (l2_req),
        .l2_wr      (l2_wr),
        .l2_wstrb   (l2_wstrb),
        .l2_data_ok (l2_data_ok),
        .l2_line    (l2_line),
        .cmd_valid  (cmd_valid),
        .cmd_wr     (cmd_wr),
        .cmd_index  (cmd_index),
        .cmd_word   (cmd_word),
        .cmd_wstrb  (cmd_wstrb),
        .cmd_wdata  (cmd_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_line   (rsp_line)
    );

    l2_line_store u_store (
        .clk       (clk),
        .rstn      (rstn),
        .cmd_valid (cmd_valid),
        .cmd_wr    (cmd_wr),
        .cmd_index (cmd_index),
        .cmd_word  (cmd_word),
        .cmd_wstrb (cmd_wstrb),
        .cmd_wdata (cmd_wdata),
        .rsp_valid (rsp_valid),
        .rsp_line  (rsp_line)
    );

endmodule

`default_nettype wire

/* rtl/l1l2_pkg.sv */
// shared definitions for the L1/L2 miss bridge
// line geometry, FSM state codes and the address view used by every stage

`default_nettype none

package l1l2_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int WORD_SEL_W = 3;
    localparam int L2_LINES   = 16;
    localparam int INDEX_W    = 4;

    // miss arbiter states
    localparam logic [2:0] ARB_IDLE    = 3'd0;
    localparam logic [2:0] ARB_I_R     = 3'd1;
    localparam logic [2:0] ARB_D_R     = 3'd2;
    localparam logic [2:0] ARB_D_W     = 3'd3;
    localparam logic [2:0] ARB_RELEASE = 3'd4;

    // request latch phases
    localparam logic [1:0] LAT_IDLE     = 2'd0;
    localparam logic [1:0] LAT_WAIT_RSP = 2'd1;
    localparam logic [1:0] LAT_WAIT_LOW = 2'd2;

    // byte address split into store fields, upper bits alias
    typedef struct packed {
        logic [22:0]           hi;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word;
        logic [1:0]            byte_off;
    } l1l2_addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        l1l2_addr_fields_t f;
    } l1l2_addr_t;

endpackage

`default_nettype wire

/* rtl/l2_line_store.sv */
// L2 line store
// 16 lines with a valid bit each, full-line reads and strobed word writes,
// answering every command through a fixed two-stage pipeline

`timescale 1ns/1ps
`default_nettype none

module l2_line_store
    import l1l2_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  cmd_valid,
    input  logic                  cmd_wr,
    input  logic [INDEX_W-1:0]    cmd_index,
    input  logic [WORD_SEL_W-1:0] cmd_word,
    input  logic [3:0]            cmd_wstrb,
    input  logic [WORD_W-1:0]     cmd_wdata,
    output logic                  rsp_valid,
    output logic [LINE_W-1:0]     rsp_line
);

    logic [LINE_W-1:0]   mem [L2_LINES];
    logic [L2_LINES-1:0] line_valid;

    logic [LINE_W-1:0] cur_line;
    logic [WORD_W-1:0] cur_word;
    logic [WORD_W-1:0] merged_word;
    logic [LINE_W-1:0] new_line;

    logic              s1_valid;
    logic [LINE_W-1:0] s1_line;

    // an invalid line reads as zero
    assign cur_line = line_valid[cmd_index] ? mem[cmd_index] : '0;
    assign cur_word = cur_line[int'(cmd_word)*WORD_W +: WORD_W];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[8*b +: 8] = cmd_wstrb[b] ? cmd_wdata[8*b +: 8] : cur_word[8*b +: 8];
        end
    end

    always_comb begin
        new_line = cur_line;
        new_line[int'(cmd_word)*WORD_W +: WORD_W] = merged_word;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_valid <= '0;
            s1_valid   <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            s1_valid  <= cmd_valid;
            rsp_valid <= s1_valid;
            if (cmd_valid && cmd_wr) begin
                line_valid[cmd_index] <= 1'b1;
            end
        end
    end

    // stage 1 updates the array, stage 2 presents the response
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_wr) begin
            mem[cmd_index] <= new_line;
        end
        if (cmd_valid) begin
            s1_line <= cmd_wr ? new_line : cur_line;
        end
        if (s1_valid) begin
            rsp_line <= s1_line;
        end
    end

endmodule

`default_nettype wire

/* rtl/l2_req_latch.sv */
// L2 request latch
// captures one granted request, decodes its address and issues a single
// store command, then completes with l2_data_ok once the store answers

`timescale 1ns/1ps
`default_nettype none

module l2_req_latch
    import l1l2_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,

    input  logic [ADDR_W-1:0]     l2_addr,
    input  logic [WORD_W-1:0]     l2_wdata,
    input  logic                  l2_req,
    input  logic                  l2_wr,
    input  logic [3:0]            l2_wstrb,
    output logic                  l2_data_ok,
    output logic [LINE_W-1:0]     l2_line,

    output logic                  cmd_valid,
    output logic                  cmd_wr,
    output logic [INDEX_W-1:0]    cmd_index,
    output logic [WORD_SEL_W-1:0] cmd_word,
    output logic [3:0]            cmd_wstrb,
    output logic [WORD_W-1:0]     cmd_wdata,
    input  logic                  rsp_valid,
    input  logic [LINE_W-1:0]     rsp_line
);

    logic [1:0]  state;
    logic        accept;
    l1l2_addr_t  addr_q;
    logic [WORD_W-1:0] wdata_q;
    logic        wr_q;
    logic [3:0]  wstrb_q;

    assign accept = (state == LAT_IDLE) && l2_req;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= LAT_IDLE;
            cmd_valid  <= 1'b0;
            l2_data_ok <= 1'b0;
        end else begin
            // one command per transaction
            cmd_valid  <= accept;
            l2_data_ok <= (state == LAT_WAIT_RSP) && rsp_valid;
            case (state)
                LAT_IDLE: begin
                    if (l2_req) begin
                        state <= LAT_WAIT_RSP;
                    end
                end
                LAT_WAIT_RSP: begin
                    if (rsp_valid) begin
                        state <= LAT_WAIT_LOW;
                    end
                end
                LAT_WAIT_LOW: begin
                    // requester must drop req before the next one
                    if (!l2_req) begin
                        state <= LAT_IDLE;
                    end
                end
                default: state <= LAT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q.raw <= l2_addr;
            wdata_q    <= l2_wdata;
            wr_q       <= l2_wr;
            wstrb_q    <= l2_wstrb;
        end
        if (rsp_valid) begin
            l2_line <= rsp_line;
        end
    end

    assign cmd_wr    = wr_q;
    assign cmd_index = addr_q.f.index;
    assign cmd_word  = addr_q.f.word;
    assign cmd_wstrb = wstrb_q;
    assign cmd_wdata = wdata_q;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# builds the L1/L2 bridge testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator is not installed or not on PATH"
    exit 1
fi

if ! verilator --binary --timing \
        --top-module tb_l1l2_bridge \
        -Mdir obj_dir \
        -o tb_l1l2_bridge \
        -f l1l2_bridge_top.f; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_l1l2_bridge 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

/* tests/tb_l1l2_bridge.sv */
// testbench for the L1/L2 miss bridge
// directed tests against a reference line memory, plus LFSR random traffic

`timescale 1ns/1ps
`default_nettype none

module tb_l1l2_bridge
    import l1l2_pkg::*;
;

    logic              clk;
    logic              rstn;
    logic [ADDR_W-1:0] icache_addr;
    logic              icache_req;
    logic              icache_data_ok;
    logic [LINE_W-1:0] icache_line;
    logic [ADDR_W-1:0] dcache_addr;
    logic [WORD_W-1:0] dcache_wdata;
    logic              dcache_req;
    logic              dcache_wr;
    logic [3:0]        dcache_wstrb;
    logic              dcache_data_ok;
    logic [LINE_W-1:0] dcache_line;

    logic [WORD_W-1:0] ref_mem [L2_LINES][LINE_WORDS];
    logic [31:0]       lfsr_state;
    int                errors;
    int                tests;
    int                failed_tests;
    int                max_wait = 64;

    l1l2_bridge_top i_dut (
        .clk            (clk),
        .rstn           (rstn),
        .icache_addr    (icache_addr),
        .icache_req     (icache_req),
        .icache_data_ok (icache_data_ok),
        .icache_line    (icache_line),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_wstrb   (dcache_wstrb),
        .dcache_data_ok (dcache_data_ok),
        .dcache_line    (dcache_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] make_addr(input logic [22:0] hi, input logic [3:0] index,
                                              input logic [2:0] word);
        l1l2_addr_t a;
        a.f.hi       = hi;
        a.f.index    = index;
        a.f.word     = word;
        a.f.byte_off = 2'b00;
        return a.raw;
    endfunction

    // word 0 sits in the low bits of a line
    function automatic logic [LINE_W-1:0] model_line(input logic [3:0] index);
        logic [LINE_W-1:0] l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*WORD_W +: WORD_W] = ref_mem[index][w];
        end
        return l;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        l1l2_addr_t a;
        a.raw = addr;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[a.f.index][a.f.word][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check_line(input string name, input logic [LINE_W-1:0] exp,
                              input logic [LINE_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic dcache_access(input logic [31:0] addr, input logic wr,
                                 input logic [31:0] wdata, input logic [3:0] wstrb);
        l1l2_addr_t a;
        int         waited;
        logic       seen;
        a.raw = addr;
        @(negedge clk);
        dcache_addr  = addr;
        dcache_wr    = wr;
        dcache_wdata = wdata;
        dcache_wstrb = wstrb;
        dcache_req   = 1'b1;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < max_wait) begin
            @(negedge clk);
            waited++;
            seen = dcache_data_ok;
        end
        if (!seen) begin
            $display("dcache access to %h got no data_ok in %0d cycles", addr, max_wait);
            errors++;
        end else if (wr) begin
            model_write(addr, wdata, wstrb);
        end else begin
            check_line("dcache_line", model_line(a.f.index), dcache_line);
        end
        dcache_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic icache_read(input logic [31:0] addr);
        l1l2_addr_t a;
        int         waited;
        logic       seen;
        a.raw = addr;
        @(negedge clk);
        icache_addr = addr;
        icache_req  = 1'b1;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < max_wait) begin
            @(negedge clk);
            waited++;
            seen = icache_data_ok;
        end
        if (!seen) begin
            $display("icache read of %h got no data_ok in %0d cycles", addr, max_wait);
            errors++;
        end else begin
            check_line("icache_line", model_line(a.f.index), icache_line);
        end
        icache_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        repeat (10) begin
            @(negedge clk);
            if (icache_data_ok !== 1'b0) begin
                $display("ERR icache_data_ok expected %h got %h", 1'b0, icache_data_ok);
                errors++;
            end
            if (dcache_data_ok !== 1'b0) begin
                $display("ERR dcache_data_ok expected %h got %h", 1'b0, dcache_data_ok);
                errors++;
            end
        end
        icache_read(make_addr(23'h1234, 4'd11, 3'd6));
        report_test("idle after reset", e0);
    endtask

    task automatic write_then_fetch();
        int e0;
        e0 = errors;
        dcache_access(make_addr(23'd0, 4'd2, 3'd5), 1'b1, 32'hdeadbeef, 4'b1111);
        icache_read(make_addr(23'd0, 4'd2, 3'd0));
        if (icache_line[5*WORD_W +: WORD_W] !== 32'hdeadbeef) begin
            $display("ERR icache_line word 5 expected %h got %h", 32'hdeadbeef,
                     icache_line[5*WORD_W +: WORD_W]);
            errors++;
        end
        report_test("write then fetch", e0);
    endtask

    task automatic strobe_merge();
        int e0;
        e0 = errors;
        dcache_access(make_addr(23'd0, 4'd7, 3'd1), 1'b1, 32'haaaa1122, 4'b0011);
        dcache_access(make_addr(23'd0, 4'd7, 3'd1), 1'b1, 32'h3344bbbb, 4'b1100);
        dcache_access(make_addr(23'd0, 4'd7, 3'd1), 1'b0, 32'd0, 4'b0000);
        if (dcache_line[WORD_W +: WORD_W] !== 32'h33441122) begin
            $display("ERR dcache_line word 1 expected %h got %h", 32'h33441122,
                     dcache_line[WORD_W +: WORD_W]);
            errors++;
        end
        report_test("strobe merge", e0);
    endtask

    task automatic both_caches_at_once();
        int   e0;
        int   waited;
        logic d_done;
        logic i_done;
        e0 = errors;
        dcache_access(make_addr(23'd0, 4'd9, 3'd0), 1'b1, 32'h01234567, 4'b1111);
        dcache_access(make_addr(23'd0, 4'd10, 3'd4), 1'b1, 32'h89abcdef, 4'b1111);
        @(negedge clk);
        dcache_addr  = make_addr(23'h55, 4'd9, 3'd0);
        dcache_wr    = 1'b0;
        dcache_wdata = 32'd0;
        dcache_wstrb = 4'b0000;
        icache_addr  = make_addr(23'd0, 4'd10, 3'd0);
        dcache_req   = 1'b1;
        icache_req   = 1'b1;
        d_done = 1'b0;
        i_done = 1'b0;
        waited = 0;
        while (!(d_done && i_done) && waited < max_wait) begin
            @(negedge clk);
            waited++;
            // icache first so a same-cycle answer counts as out of order
            if (icache_data_ok) begin
                if (!d_done) begin
                    $display("icache was served before the waiting dcache request");
                    errors++;
                end
                check_line("icache_line", model_line(4'd10), icache_line);
                icache_req = 1'b0;
                i_done     = 1'b1;
            end
            if (dcache_data_ok) begin
                check_line("dcache_line", model_line(4'd9), dcache_line);
                dcache_req = 1'b0;
                d_done     = 1'b1;
            end
        end
        if (!(d_done && i_done)) begin
            $display("simultaneous requests not both answered in %0d cycles", max_wait);
            errors++;
        end
        dcache_req = 1'b0;
        icache_req = 1'b0;
        @(negedge clk);
        report_test("both caches at once", e0);
    endtask

    task automatic address_alias();
        int e0;
        e0 = errors;
        dcache_access(make_addr(23'h12345, 4'd5, 3'd3), 1'b1, 32'hcafef00d, 4'b1111);
        dcache_access(make_addr(23'h007ab, 4'd5, 3'd3), 1'b0, 32'd0, 4'b0000);
        if (dcache_line[3*WORD_W +: WORD_W] !== 32'hcafef00d) begin
            $display("ERR dcache_line word 3 expected %h got %h", 32'hcafef00d,
                     dcache_line[3*WORD_W +: WORD_W]);
            errors++;
        end
        report_test("address alias", e0);
    endtask

    task automatic random_traffic();
        int          e0;
        logic [31:0] r;
        logic [3:0]  idx;
        logic [2:0]  wsel;
        logic [22:0] hi;
        logic [31:0] data;
        logic [3:0]  strb;
        e0 = errors;
        repeat (24) begin
            r    = rand_bits(4);
            idx  = r[3:0];
            r    = rand_bits(3);
            wsel = r[2:0];
            r    = rand_bits(8);
            hi   = {15'd0, r[7:0]};
            data = rand_bits(32);
            r    = rand_bits(4);
            strb = r[3:0];
            dcache_access(make_addr(hi, idx, wsel), 1'b1, data, strb);
            // read the written line back through either cache
            r = rand_bits(1);
            if (r[0]) begin
                icache_read(make_addr(23'd0, idx, 3'd0));
            end else begin
                dcache_access(make_addr(23'd0, idx, 3'd0), 1'b0, 32'd0, 4'b0000);
            end
            r = rand_bits(4);
            icache_read(make_addr(23'd0, r[3:0], 3'd0));
        end
        report_test("random traffic", e0);
    endtask

    initial begin
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        lfsr_state   = 32'd32;
        rstn         = 1'b0;
        icache_addr  = '0;
        icache_req   = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_wstrb = 4'b0000;
        for (int i = 0; i < L2_LINES; i++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                ref_mem[i][w] = '0;
            end
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        idle_after_reset();
        write_then_fetch();
        strobe_merge();
        both_caches_at_once();
        address_alias();
        random_traffic();

        $display("tests %0d, failing %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
